// ==== rtl/irPkg.sv ====
`default_nettype none

package irPkg;

  // Instruction field latched from the cache or adder
  localparam int irWidth = 13;
  localparam int adWidth = 36;

  // Dispatch RAM word and address
  localparam int dramWidth = 15;
  localparam int dramAddrBits = 9;

  // Dispatch word layout, bit 0 first
  localparam int dramAPos = 0;
  localparam int dramBPos = 3;
  localparam int dramParPos = 6;
  localparam int dramJLoPos = 7;
  localparam int dramJHiPos = 11;

  // Adder slices for the normalize encoder
  localparam int sliceWidth = 6;
  localparam int numSlices = 6;
  localparam int posWidth = $clog2(sliceWidth);
  localparam int normWidth = 3;

  // Diagnostic load functions
  localparam int diagFuncWidth = 3;
  localparam logic [diagFuncWidth-1:0] diagWrDram = 3'd0;
  localparam logic [diagFuncWidth-1:0] diagSetIoJrst = 3'd5;
  localparam logic [diagFuncWidth-1:0] diagSetAc = 3'd6;
  localparam logic [diagFuncWidth-1:0] diagClrEn = 3'd7;

  // JRST is opcode 254
  localparam logic [0:8] jrstOpcode = 9'o254;

endpackage

`default_nettype wire

// ==== rtl/adSlicePrio.sv ====
`timescale 1ns/1ns
`default_nettype none

module adSlicePrio (
  input  logic [0:irPkg::sliceWidth-1] bits,
  output logic anyOne,
  output logic [irPkg::posWidth-1:0] firstPos
);
  import irPkg::*;

  assign anyOne = |bits;

  // Scan from the far end so the lowest set index wins
  always_comb begin
    firstPos = '0;
    for (int i = sliceWidth - 1; i >= 0; i--) begin
      if (bits[i]) begin
        firstPos = posWidth'(i);
      end
    end
  end

endmodule

`default_nettype wire

// ==== rtl/instrReg.sv ====
`timescale 1ns/1ns
`default_nettype none

module instrReg (
  input  logic CON_LOAD_DRAM,
  input  logic arstN,
  input  logic loadIr,
  input  logic mbXfer,
  input  logic [0:irPkg::irWidth-1] cacheData,
  input  logic [0:irPkg::irWidth-1] adHigh,
  input  logic diagLoad,
  input  logic [irPkg::diagFuncWidth-1:0] diagFunc,
  output logic [0:irPkg::irWidth-1] ir,
  output logic [9:12] irAc,
  output logic jrst,
  output logic ioLegal,
  output logic enIoJrst,
  output logic enAc
);
  import irPkg::*;

  logic [0:irWidth-1] nextIr;

  // MB transfer takes the instruction from the adder instead of the cache
  assign nextIr = mbXfer ? adHigh : cacheData;

  always_ff @(posedge CON_LOAD_DRAM or negedge arstN) begin
    if (!arstN) begin
      ir <= '0;
      irAc <= '0;
    end else if (loadIr) begin
      ir <= nextIr;
      // AC field only passes when the AC enable is set
      irAc <= enAc ? nextIr[9:12] : 4'b0000;
    end
  end

  // Enable flags are set and cleared by diagnostic functions
  always_ff @(posedge CON_LOAD_DRAM or negedge arstN) begin
    if (!arstN) begin
      enIoJrst <= 1'b0;
      enAc <= 1'b0;
    end else if (diagLoad) begin
      case (diagFunc)
        diagSetIoJrst: begin
          enIoJrst <= 1'b1;
        end
        diagSetAc: begin
          enAc <= 1'b1;
        end
        diagClrEn: begin
          enIoJrst <= 1'b0;
          enAc <= 1'b0;
        end
        default: begin
          enIoJrst <= enIoJrst;
        end
      endcase
    end
  end

  // Opcode compare ignores the AC field
  assign jrst = (ir[0:8] == jrstOpcode);

  // Device codes with bits 3 to 6 set
  assign ioLegal = &ir[3:6];

endmodule

`default_nettype wire

// ==== rtl/dramDispatch.sv ====
`timescale 1ns/1ns
`default_nettype none

module dramDispatch #(
  parameter int dramDepth = 512
) (
  input  logic CON_LOAD_DRAM,
  input  logic arstN,
  input  logic loadDram,
  input  logic [0:irPkg::irWidth-1] ir,
  input  logic jrst,
  input  logic enIoJrst,
  input  logic diagLoad,
  input  logic [irPkg::diagFuncWidth-1:0] diagFunc,
  input  logic [0:irPkg::dramWidth-1] dramWrData,
  output logic [0:irPkg::dramAddrBits-1] dramAddr,
  output logic [0:2] dramA,
  output logic [0:2] dramB,
  output logic [0:10] dramJ,
  output logic dramParBit,
  output logic dramOddParity
);
  import irPkg::*;

  localparam int idxBits = $clog2(dramDepth);

  logic [0:dramWidth-1] dram [0:dramDepth-1];

  logic instr7xx;
  logic instr3to6;
  logic [0:dramAddrBits-1] nextAddr;
  logic [idxBits-1:0] dramIdx;
  logic dramWrEn;

  logic readPend;
  logic jrstHold;
  logic [0:3] acHold;
  logic [0:dramWidth-1] dramWord;
  logic [0:3] jHigh;

  // I/O instructions only when the diagnostic enable allows them
  assign instr7xx = (&ir[0:2]) & enIoJrst;
  assign instr3to6 = &ir[3:6];

  always_comb begin
    if (instr7xx) begin
      nextAddr = {3'b111, ir[7:9] | {3{instr3to6}}, ir[10:12]};
    end else begin
      nextAddr = ir[0:8];
    end
  end

  // Low address bits index a smaller RAM
  assign dramIdx = dramAddr[dramAddrBits-idxBits:dramAddrBits-1];

  assign dramWrEn = diagLoad && (diagFunc == diagWrDram);

  // Address stage, with the JRST override captured alongside
  always_ff @(posedge CON_LOAD_DRAM or negedge arstN) begin
    if (!arstN) begin
      dramAddr <= '0;
      readPend <= 1'b0;
      jrstHold <= 1'b0;
      acHold <= '0;
    end else begin
      readPend <= loadDram;
      if (loadDram) begin
        dramAddr <= nextAddr;
        jrstHold <= jrst;
        acHold <= ir[9:12];
      end
    end
  end

  // Diagnostic write port
  always_ff @(posedge CON_LOAD_DRAM) begin
    if (dramWrEn) begin
      dram[dramIdx] <= dramWrData;
    end
  end

  // Registered read one edge after the address
  always_ff @(posedge CON_LOAD_DRAM or negedge arstN) begin
    if (!arstN) begin
      dramWord <= '0;
      jHigh <= '0;
    end else if (readPend) begin
      dramWord <= dram[dramIdx];
      if (jrstHold) begin
        jHigh <= acHold;
      end else begin
        jHigh <= dram[dramIdx][dramJHiPos +: 4];
      end
    end
  end

  assign dramA = dramWord[dramAPos +: 3];
  assign dramB = dramWord[dramBPos +: 3];
  assign dramParBit = dramWord[dramParPos];

  // J bits 0, 5 and 6 are not stored
  assign dramJ = {1'b0, dramWord[dramJLoPos +: 4], 2'b00, jHigh};

  // Parity covers the stored word, not the JRST override
  assign dramOddParity = ^dramWord;

endmodule

`default_nettype wire

// ==== rtl/normEncode.sv ====
`timescale 1ns/1ns
`default_nettype none

module normEncode #(
  parameter int numSlices = irPkg::numSlices
) (
  input  logic [0:numSlices-1] anyOne,
  input  logic [0:numSlices-1][irPkg::posWidth-1:0] firstPos,
  input  logic adSign,
  input  logic adCarryOut,
  input  logic magic7,
  input  logic magic8,
  input  logic [0:2] dramB,
  output logic [irPkg::normWidth-1:0] norm,
  output logic adEq0,
  output logic testSatisfied
);
  import irPkg::*;

  logic anyLater;
  logic termEq;
  logic termGt;
  logic termLt;
  logic termCarry;

  always_comb begin
    anyLater = 1'b0;
    for (int i = 2; i < numSlices; i++) begin
      anyLater = anyLater | anyOne[i];
    end

    // Slice 0 holds bits 0-5, slice 1 holds bits 6-11
    if (anyOne[0]) begin
      norm = (firstPos[0] == '0) ? normWidth'(1) : normWidth'(2);
    end else if (anyOne[1]) begin
      if (firstPos[1] == '0) begin
        norm = normWidth'(2);
      end else if (firstPos[1] < posWidth'(5)) begin
        // Bits 7 to 10 map to codes 3 to 6
        norm = normWidth'(firstPos[1]) + normWidth'(2);
      end else begin
        norm = normWidth'(7);
      end
    end else if (anyLater) begin
      norm = normWidth'(7);
    end else begin
      norm = '0;
    end
  end

  assign adEq0 = ~|anyOne;

  // B field selects the EQ, GT and LT conditions
  assign termEq = dramB[1] & adEq0;
  assign termGt = dramB[2] & magic7 & (adSign ^ adCarryOut);
  assign termLt = dramB[2] & magic8 & adSign;
  assign termCarry = (magic7 == magic8) & adCarryOut;

  // B bit 0 inverts the sense of the test
  assign testSatisfied = (termEq | termGt | termLt | termCarry) ^ dramB[0];

endmodule

`default_nettype wire

// ==== rtl/irDiagMux.sv ====
`timescale 1ns/1ns
`default_nettype none

module irDiagMux (
  input  logic diagRead,
  input  logic [irPkg::diagFuncWidth-1:0] diagSel,
  input  logic [irPkg::normWidth-1:0] norm,
  input  logic [0:irPkg::dramAddrBits-1] dramAddr,
  input  logic enIoJrst,
  input  logic enAc,
  input  logic [9:12] irAc,
  input  logic [0:2] dramA,
  input  logic [0:2] dramB,
  input  logic testSatisfied,
  input  logic jrst,
  input  logic [0:irPkg::irWidth-1] ir,
  input  logic [0:10] dramJ,
  input  logic dramParBit,
  input  logic dramOddParity,
  input  logic adEq0,
  input  logic ioLegal,
  input  logic adCarryOut,
  output logic [0:5] ebusData,
  output logic ebusDrive
);
  import irPkg::*;

  logic jrst0;
  logic [0:5] diagWord;

  // JRST with a zero AC field
  assign jrst0 = jrst & (ir[9:irWidth-1] == '0);

  always_comb begin
    case (diagSel)
      3'd0: diagWord = {norm, dramAddr[0:2]};
      3'd1: diagWord = dramAddr[3:8];
      3'd2: diagWord = {enIoJrst, enAc, irAc};
      3'd3: diagWord = {dramA, dramB};
      3'd4: diagWord = {testSatisfied, jrst0, dramJ[1:4]};
      3'd5: diagWord = {dramParBit, dramOddParity, dramJ[7:10]};
      3'd6: diagWord = {adEq0, ioLegal, adCarryOut, 3'b000};
      default: diagWord = ir[0:5];
    endcase
  end

  // Bus stays quiet unless a diagnostic read is active
  assign ebusDrive = diagRead;
  assign ebusData = diagRead ? diagWord : 6'b000000;

endmodule

`default_nettype wire

// ==== rtl/irBoard.sv ====
`timescale 1ns/1ns
`default_nettype none

module irBoard #(
  parameter int dramDepth = 512,
  parameter int numSlices = irPkg::numSlices
) (
  input  logic CON_LOAD_DRAM,
  input  logic arstN,
  input  logic [0:irPkg::adWidth-1] cacheData,
  input  logic [0:irPkg::adWidth-1] adBus,
  input  logic adCarryOut,
  input  logic magic7,
  input  logic magic8,
  input  logic loadIr,
  input  logic loadDram,
  input  logic diagLoad,
  input  logic mbXfer,
  input  logic [irPkg::diagFuncWidth-1:0] diagFunc,
  input  logic [0:irPkg::dramWidth-1] dramWrData,
  input  logic diagRead,
  input  logic [irPkg::diagFuncWidth-1:0] diagSel,
  output logic [0:irPkg::irWidth-1] ir,
  output logic [9:12] irAc,
  output logic [0:2] dramA,
  output logic [0:2] dramB,
  output logic [0:10] dramJ,
  output logic dramOddParity,
  output logic [irPkg::normWidth-1:0] norm,
  output logic testSatisfied,
  output logic [0:5] ebusData,
  output logic ebusDrive
);
  import irPkg::*;

  logic jrst;
  logic ioLegal;
  logic enIoJrst;
  logic enAc;
  logic [0:dramAddrBits-1] dramAddr;
  logic dramParBit;
  logic [0:numSlices-1] anyOne;
  logic [0:numSlices-1][posWidth-1:0] firstPos;
  logic adEq0;

  instrReg instrRegInst (
    .CON_LOAD_DRAM(CON_LOAD_DRAM),
    .arstN(arstN),
    .loadIr(loadIr),
    .mbXfer(mbXfer),
    .cacheData(cacheData[0:irWidth-1]),
    .adHigh(adBus[0:irWidth-1]),
    .diagLoad(diagLoad),
    .diagFunc(diagFunc),
    .ir(ir),
    .irAc(irAc),
    .jrst(jrst),
    .ioLegal(ioLegal),
    .enIoJrst(enIoJrst),
    .enAc(enAc)
  );

  dramDispatch #(
    .dramDepth(dramDepth)
  ) dramDispatchInst (
    .CON_LOAD_DRAM(CON_LOAD_DRAM),
    .arstN(arstN),
    .loadDram(loadDram),
    .ir(ir),
    .jrst(jrst),
    .enIoJrst(enIoJrst),
    .diagLoad(diagLoad),
    .diagFunc(diagFunc),
    .dramWrData(dramWrData),
    .dramAddr(dramAddr),
    .dramA(dramA),
    .dramB(dramB),
    .dramJ(dramJ),
    .dramParBit(dramParBit),
    .dramOddParity(dramOddParity)
  );

  // One priority encoder per six adder bits
  for (genvar i = 0; i < numSlices; i++) begin : gSlice
    adSlicePrio slicePrioInst (
      .bits(adBus[i*sliceWidth +: sliceWidth]),
      .anyOne(anyOne[i]),
      .firstPos(firstPos[i])
    );
  end

  normEncode #(
    .numSlices(numSlices)
  ) normEncodeInst (
    .anyOne(anyOne),
    .firstPos(firstPos),
    .adSign(adBus[0]),
    .adCarryOut(adCarryOut),
    .magic7(magic7),
    .magic8(magic8),
    .dramB(dramB),
    .norm(norm),
    .adEq0(adEq0),
    .testSatisfied(testSatisfied)
  );

  irDiagMux irDiagMuxInst (
    .diagRead(diagRead),
    .diagSel(diagSel),
    .norm(norm),
    .dramAddr(dramAddr),
    .enIoJrst(enIoJrst),
    .enAc(enAc),
    .irAc(irAc),
    .dramA(dramA),
    .dramB(dramB),
    .testSatisfied(testSatisfied),
    .jrst(jrst),
    .ir(ir),
    .dramJ(dramJ),
    .dramParBit(dramParBit),
    .dramOddParity(dramOddParity),
    .adEq0(adEq0),
    .ioLegal(ioLegal),
    .adCarryOut(adCarryOut),
    .ebusData(ebusData),
    .ebusDrive(ebusDrive)
  );

endmodule

`default_nettype wire

// ==== dv/irBoardTb.sv ====
`timescale 1ns/1ns
`default_nettype none

module irBoardTb;

  localparam int dramDepth = 512;
  localparam int resetCycles = 5;
  localparam int driveDelay = 2;
  localparam int sampleDelay = 10;
  localparam int dramLatency = 2;
  localparam int timeoutNs = 5000000;

  // Diagnostic function codes and the JRST opcode
  localparam logic [2:0] fnWrDram = 3'd0;
  localparam logic [2:0] fnSetIoJrst = 3'd5;
  localparam logic [2:0] fnSetAc = 3'd6;
  localparam logic [2:0] fnClrEn = 3'd7;
  localparam logic [0:8] opJrst = 9'o254;

  // Row kinds
  localparam logic [2:0] opIr = 3'd0;
  localparam logic [2:0] opAddr = 3'd1;
  localparam logic [2:0] opDram = 3'd2;
  localparam logic [2:0] opDiag = 3'd3;
  localparam logic [2:0] opComb = 3'd4;
  localparam logic [2:0] opRead = 3'd5;

  typedef struct packed {
    logic [2:0] op;
    logic [0:35] data;
    logic mbx;
    logic [2:0] func;
    logic [0:14] wr;
    logic m7;
    logic m8;
    logic carry;
    logic rd;
    logic [2:0] sel;
    logic [0:12] expIr;
    logic [9:12] expIrAc;
    logic [0:2] expA;
    logic [0:2] expB;
    logic [0:10] expJ;
    logic expOdd;
    logic [2:0] expNorm;
    logic expTs;
    logic [0:5] expEbus;
    logic expDrive;
  } rowT;

  logic CON_LOAD_DRAM;
  logic arstN;
  logic [0:35] cacheData;
  logic [0:35] adBus;
  logic adCarryOut;
  logic magic7;
  logic magic8;
  logic loadIr;
  logic loadDram;
  logic diagLoad;
  logic mbXfer;
  logic [2:0] diagFunc;
  logic [0:14] dramWrData;
  logic diagRead;
  logic [2:0] diagSel;
  logic [0:12] ir;
  logic [9:12] irAc;
  logic [0:2] dramA;
  logic [0:2] dramB;
  logic [0:10] dramJ;
  logic dramOddParity;
  logic [2:0] norm;
  logic testSatisfied;
  logic [0:5] ebusData;
  logic ebusDrive;

  // Reference model state
  logic [0:12] mIr;
  logic [9:12] mIrAc;
  logic mEnIo;
  logic mEnAc;
  logic [0:8] mAddr;
  logic [0:14] mDram [0:dramDepth-1];
  logic [0:2] mA;
  logic [0:2] mB;
  logic mPar;
  logic mOdd;
  logic [0:10] mJ;
  logic [0:35] mAd;
  logic mM7;
  logic mM8;
  logic mCarry;
  logic mRd;
  logic [2:0] mSel;

  rowT rows[$];
  int checkCount = 0;
  int errorCount = 0;

  irBoard #(
    .dramDepth(dramDepth)
  ) irBoard_inst (
    .CON_LOAD_DRAM(CON_LOAD_DRAM),
    .arstN(arstN),
    .cacheData(cacheData),
    .adBus(adBus),
    .adCarryOut(adCarryOut),
    .magic7(magic7),
    .magic8(magic8),
    .loadIr(loadIr),
    .loadDram(loadDram),
    .diagLoad(diagLoad),
    .mbXfer(mbXfer),
    .diagFunc(diagFunc),
    .dramWrData(dramWrData),
    .diagRead(diagRead),
    .diagSel(diagSel),
    .ir(ir),
    .irAc(irAc),
    .dramA(dramA),
    .dramB(dramB),
    .dramJ(dramJ),
    .dramOddParity(dramOddParity),
    .norm(norm),
    .testSatisfied(testSatisfied),
    .ebusData(ebusData),
    .ebusDrive(ebusDrive)
  );

  initial begin
    CON_LOAD_DRAM = 1'b0;
    forever #20 CON_LOAD_DRAM = ~CON_LOAD_DRAM;
  end

  initial begin
    #(timeoutNs);
    $display("Timeout: the run did not reach its end in time");
    $display("Testbench failed");
    $finish;
  end

  function automatic logic [0:35] rand36();
    return 36'({$urandom, $urandom});
  endfunction

  function automatic logic [0:14] rand15();
    return 15'($urandom);
  endfunction

  // Leading set bit, counted from bit 0
  function automatic logic [2:0] normRef(input logic [0:35] ad);
    int lead;
    lead = -1;
    for (int i = 35; i >= 0; i--) begin
      if (ad[i]) begin
        lead = i;
      end
    end
    if (lead < 0) begin
      return 3'd0;
    end else if (lead == 0) begin
      return 3'd1;
    end else if (lead <= 6) begin
      return 3'd2;
    end else if (lead <= 10) begin
      return 3'(lead - 4);
    end
    return 3'd7;
  endfunction

  function automatic logic tsRef(input logic [0:2] b, input logic m7, input logic m8,
                                 input logic sign, input logic carry, input logic eq0);
    logic t;
    t = (b[1] & eq0) | (b[2] & m7 & (sign ^ carry)) | (b[2] & m8 & sign)
        | ((m7 == m8) & carry);
    return t ^ b[0];
  endfunction

  function automatic logic [0:8] addrRef(input logic [0:12] i, input logic enIo);
    if ((&i[0:2]) && enIo) begin
      return {3'b111, i[7:9] | {3{&i[3:6]}}, i[10:12]};
    end
    return i[0:8];
  endfunction

  function automatic logic tsNow();
    return tsRef(mB, mM7, mM8, mAd[0], mCarry, mAd == 36'd0);
  endfunction

  function automatic logic [0:5] diagRef(input logic [2:0] sel);
    case (sel)
      3'd0: return {normRef(mAd), mAddr[0:2]};
      3'd1: return mAddr[3:8];
      3'd2: return {mEnIo, mEnAc, mIrAc};
      3'd3: return {mA, mB};
      3'd4: return {tsNow(), (mIr[0:8] == opJrst) && (mIr[9:12] == 4'd0), mJ[1:4]};
      3'd5: return {mPar, mOdd, mJ[7:10]};
      3'd6: return {mAd == 36'd0, &mIr[3:6], mCarry, 3'b000};
      default: return mIr[0:5];
    endcase
  endfunction

  function automatic rowT expectRow();
    rowT r;
    r = '0;
    r.expIr = mIr;
    r.expIrAc = mIrAc;
    r.expA = mA;
    r.expB = mB;
    r.expJ = mJ;
    r.expOdd = mOdd;
    r.expNorm = normRef(mAd);
    r.expTs = tsNow();
    r.expEbus = mRd ? diagRef(mSel) : 6'd0;
    r.expDrive = mRd;
    return r;
  endfunction

  task automatic addIr(input logic [0:35] d, input logic mbx);
    rowT r;
    mIr = d[0:12];
    mIrAc = mEnAc ? d[9:12] : 4'd0;
    mAd = mbx ? d : ~d;
    r = expectRow();
    r.op = opIr;
    r.data = d;
    r.mbx = mbx;
    rows.push_back(r);
  endtask

  task automatic addLoadDram(input logic checked);
    logic [0:14] w;
    rowT r;
    mAddr = addrRef(mIr, mEnIo);
    w = mDram[mAddr];
    mA = w[0:2];
    mB = w[3:5];
    mPar = w[6];
    // JRST puts the AC field into J bits 7-10
    mJ = {1'b0, w[7:10], 2'b00, (mIr[0:8] == opJrst) ? mIr[9:12] : w[11:14]};
    mOdd = ^w;
    r = expectRow();
    r.op = checked ? opDram : opAddr;
    rows.push_back(r);
  endtask

  task automatic addDiag(input logic [2:0] fn, input logic [0:14] wr);
    rowT r;
    case (fn)
      fnWrDram: mDram[mAddr] = wr;
      fnSetIoJrst: mEnIo = 1'b1;
      fnSetAc: mEnAc = 1'b1;
      fnClrEn: begin
        mEnIo = 1'b0;
        mEnAc = 1'b0;
      end
      default: mEnIo = mEnIo;
    endcase
    r = expectRow();
    r.op = opDiag;
    r.func = fn;
    r.wr = wr;
    rows.push_back(r);
  endtask

  task automatic addComb(input logic [0:35] ad, input logic m7, input logic m8,
                         input logic carry);
    rowT r;
    mAd = ad;
    mM7 = m7;
    mM8 = m8;
    mCarry = carry;
    r = expectRow();
    r.op = opComb;
    r.data = ad;
    r.m7 = m7;
    r.m8 = m8;
    r.carry = carry;
    rows.push_back(r);
  endtask

  task automatic addRead(input logic [2:0] sel, input logic rd);
    rowT r;
    mSel = sel;
    mRd = rd;
    r = expectRow();
    r.op = opRead;
    r.sel = sel;
    r.rd = rd;
    rows.push_back(r);
  endtask

  task automatic buildTable();
    logic [0:35] d;
    logic [0:14] w;
    mIr = '0;
    mIrAc = '0;
    mEnIo = 1'b0;
    mEnAc = 1'b0;
    mAddr = '0;
    mA = '0;
    mB = '0;
    mPar = 1'b0;
    mOdd = 1'b0;
    mJ = '0;
    mAd = '0;
    mM7 = 1'b0;
    mM8 = 1'b0;
    mCarry = 1'b0;
    mRd = 1'b0;
    mSel = '0;
    // Fill every dispatch entry through the diagnostic write
    for (int a = 0; a < dramDepth; a++) begin
      d = rand36();
      d[0:8] = 9'(a);
      addIr(d, 1'b0);
      addLoadDram(1'b0);
      addDiag(fnWrDram, rand15());
    end
    // IR source select, then the AC copy once enabled
    addIr(rand36(), 1'b0);
    addIr(rand36(), 1'b1);
    addDiag(fnSetAc, 15'd0);
    addIr(rand36(), 1'b0);
    addIr(rand36(), 1'b1);
    for (int n = 0; n < 6; n++) begin
      addIr(rand36(), n[0]);
      addLoadDram(1'b1);
    end
    d = rand36();
    addIr(d, 1'b0);
    addLoadDram(1'b0);
    addDiag(fnWrDram, rand15());
    addLoadDram(1'b1);
    d[0:8] = opJrst;
    addIr(d, 1'b1);
    addLoadDram(1'b1);
    // I/O address rule with the enable set, then cleared
    addDiag(fnSetIoJrst, 15'd0);
    d = rand36();
    d[0:6] = 7'b1111111;
    addIr(d, 1'b0);
    addLoadDram(1'b1);
    d[3:6] = 4'b0101;
    addIr(d, 1'b0);
    addLoadDram(1'b1);
    addDiag(fnClrEn, 15'd0);
    addIr(d, 1'b0);
    addLoadDram(1'b1);
    // Word 6 carries the adder zero flag
    addRead(3'd6, 1'b1);
    // Leading bit at each of 0 to 11, a few later ones, and zero
    addComb(36'd0, 1'b0, 1'b0, 1'b0);
    for (int k = 0; k < 36; k++) begin
      if (k < 12 || k == 17 || k == 29 || k == 35) begin
        d = rand36();
        for (int j = 0; j < k; j++) begin
          d[j] = 1'b0;
        end
        d[k] = 1'b1;
        addComb(d, 1'($urandom), 1'($urandom), 1'($urandom));
      end
    end
    for (int n = 0; n < 16; n++) begin
      d = rand36() >> ($urandom % 36);
      addComb(d, 1'($urandom), 1'($urandom), 1'($urandom));
    end
    // Every B value against magic, sign, carry and zero
    for (int b = 0; b < 8; b++) begin
      d = rand36();
      d[0:8] = 9'(400 + b);
      addIr(d, 1'b0);
      addLoadDram(1'b0);
      w = rand15();
      w[3:5] = 3'(b);
      addDiag(fnWrDram, w);
      addLoadDram(1'b1);
      for (int m = 0; m < 8; m++) begin
        addComb(36'd0, m[2], m[1], m[0]);
        d = rand36();
        d[0] = 1'b0;
        d[35] = 1'b1;
        addComb(d, m[2], m[1], m[0]);
        d[0] = 1'b1;
        addComb(d, m[2], m[1], m[0]);
      end
    end
    // Readback with a JRST 0 state, then an I/O state
    addDiag(fnSetAc, 15'd0);
    addDiag(fnSetIoJrst, 15'd0);
    for (int p = 0; p < 2; p++) begin
      d = rand36();
      if (p == 0) begin
        d[0:12] = {opJrst, 4'd0};
      end else begin
        d[0:6] = 7'b1111111;
      end
      addIr(d, 1'b1);
      addLoadDram(1'b1);
      addComb(rand36(), 1'($urandom), 1'($urandom), 1'b1);
      for (int s = 0; s < 8; s++) begin
        addRead(3'(s), 1'b1);
      end
      for (int s = 0; s < 8; s++) begin
        addRead(3'(s), 1'b0);
      end
    end
  endtask

  task automatic checkVal(input string name, input logic [63:0] got, input logic [63:0] exp);
    checkCount++;
    if (got !== exp) begin
      errorCount++;
      $display("[ERROR] %0t ns %s: got %0h, expected %0h", $time, name, got, exp);
    end
  endtask

  task automatic nextDrive();
    @(posedge CON_LOAD_DRAM);
    #(driveDelay);
  endtask

  task automatic applyRow(input rowT r);
    nextDrive();
    case (r.op)
      opIr: begin
        mbXfer = r.mbx;
        cacheData = r.mbx ? ~r.data : r.data;
        adBus = r.mbx ? r.data : ~r.data;
        loadIr = 1'b1;
        nextDrive();
        loadIr = 1'b0;
        #(sampleDelay);
        checkVal("ir", 64'(ir), 64'(r.expIr));
        checkVal("irAc", 64'(irAc), 64'(r.expIrAc));
      end
      opAddr, opDram: begin
        loadDram = 1'b1;
        nextDrive();
        loadDram = 1'b0;
        for (int k = 1; k < dramLatency; k++) begin
          nextDrive();
        end
        #(sampleDelay);
        if (r.op == opDram) begin
          checkVal("dramA", 64'(dramA), 64'(r.expA));
          checkVal("dramB", 64'(dramB), 64'(r.expB));
          checkVal("dramJ", 64'(dramJ), 64'(r.expJ));
          checkVal("dramOddParity", 64'(dramOddParity), 64'(r.expOdd));
        end
      end
      opDiag: begin
        diagFunc = r.func;
        dramWrData = r.wr;
        diagLoad = 1'b1;
        nextDrive();
        diagLoad = 1'b0;
      end
      opComb: begin
        adBus = r.data;
        magic7 = r.m7;
        magic8 = r.m8;
        adCarryOut = r.carry;
        #(sampleDelay);
        checkVal("norm", 64'(norm), 64'(r.expNorm));
        checkVal("testSatisfied", 64'(testSatisfied), 64'(r.expTs));
        checkVal("ebusData", 64'(ebusData), 64'(r.expEbus));
      end
      default: begin
        diagRead = r.rd;
        diagSel = r.sel;
        #(sampleDelay);
        checkVal("ebusData", 64'(ebusData), 64'(r.expEbus));
        checkVal("ebusDrive", 64'(ebusDrive), 64'(r.expDrive));
      end
    endcase
  endtask

  initial begin
    void'($urandom(32'he043_8ced));
    arstN = 1'b0;
    cacheData = '0;
    adBus = '0;
    adCarryOut = 1'b0;
    magic7 = 1'b0;
    magic8 = 1'b0;
    loadIr = 1'b0;
    loadDram = 1'b0;
    diagLoad = 1'b0;
    mbXfer = 1'b0;
    diagFunc = '0;
    dramWrData = '0;
    diagRead = 1'b0;
    diagSel = '0;
    for (int c = 0; c < resetCycles; c++) begin
      @(posedge CON_LOAD_DRAM);
    end
    #(driveDelay);
    arstN = 1'b1;
    #(sampleDelay);
    checkVal("ir", 64'(ir), 64'(0));
    checkVal("irAc", 64'(irAc), 64'(0));
    checkVal("dramA", 64'(dramA), 64'(0));
    checkVal("dramB", 64'(dramB), 64'(0));
    checkVal("dramJ", 64'(dramJ), 64'(0));
    checkVal("ebusDrive", 64'(ebusDrive), 64'(0));
    checkVal("ebusData", 64'(ebusData), 64'(0));
    buildTable();
    for (int i = 0; i < rows.size(); i++) begin
      applyRow(rows[i]);
    end
    $display("Rows: %0d  Checks: %0d  Errors: %0d", rows.size(), checkCount, errorCount);
    if (errorCount == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== src.f ====
rtl/irPkg.sv
rtl/adSlicePrio.sv
rtl/instrReg.sv
rtl/dramDispatch.sv
rtl/normEncode.sv
rtl/irDiagMux.sv
rtl/irBoard.sv
dv/irBoardTb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS = --binary --timing --timescale 1ns/1ns -j 0
TOP = irBoardTb
FILELIST = src.f
OBJDIR = obj_dir
LOG = sim.log

SIM = $(OBJDIR)/V$(TOP)
SOURCES = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# Rebuilt only when a listed source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(SIM)
	$(SIM) | tee $(LOG)
	@if grep -q "Testbench failed" $(LOG); then exit 1; fi
	@grep -q "Testbench passed" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
